//--- files.f
source/mmio_wide_pkg.sv
source/onehot_counter.sv
source/onehot_mux.sv
source/mmio_wide_read.sv
source/mmio_wide_write.sv
source/wide_timer.sv
source/mmio_reg_decoder.sv
source/mmio_wide_timer_top.sv
bench/tb_mmio_wide_timer.sv

//--- run_sim.sh
#!/bin/sh
# Builds the wide timer testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_mmio_wide_timer \
	&& ./obj_dir/Vtb_mmio_wide_timer | tee /dev/stderr | grep -q "Simulation PASSED" \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail"; exit 1; }

exit 0

//--- bench/tb_mmio_wide_timer.sv
// Table-driven testbench for the MMIO wide timer with a cycle model of the register map
`timescale 1ns/10ps
`default_nettype none

module tb_mmio_wide_timer;

	import mmio_wide_pkg::*;

	localparam int BW_WIDE       = 64;
	localparam int NUM_WORDS     = (BW_WIDE + MMIO_DW - 1) / MMIO_DW;
	localparam int PAD_W         = NUM_WORDS * MMIO_DW;
	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 10;
	localparam int RESET_TIMEOUT = 50;
	localparam int MAX_STEPS     = 64;
	localparam int RUN_CYCLES    = 7;

	// Step operations
	localparam logic [1:0] OP_IDLE  = 2'd0;
	localparam logic [1:0] OP_READ  = 2'd1;
	localparam logic [1:0] OP_WRITE = 2'd2;

	// One bus cycle of stimulus with its expected read data
	typedef struct packed {
		logic [1:0]         op;
		logic [MMIO_AW-1:0] addr;
		logic [MMIO_DW-1:0] wdata;
		logic               check;
		logic [MMIO_DW-1:0] expected;
	} step_t;

	logic               clk;
	logic               rst_n;
	mmio_req_t          req;
	logic [MMIO_DW-1:0] rdata;

	step_t       steps [MAX_STEPS];
	int          num_steps;
	int          checks_done;
	logic [31:0] lfsr_state;

	// Model state, one update per table step
	logic [BW_WIDE-1:0] m_count;
	logic [BW_WIDE-1:0] m_snapshot;
	logic [PAD_W-1:0]   m_gather;
	logic               m_run;
	logic               m_clr_pending;
	int                 m_rd_idx;
	int                 m_wr_idx;

	mmio_wide_timer_top #(.BW_WIDE(BW_WIDE)) dut0 (
		.clk  (clk),
		.rst_n(rst_n),
		.req  (req),
		.rdata(rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// Reset held over ten rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		for (int k = 0; k < RESET_CYCLES; k++) begin
			@(posedge clk);
		end
		@(negedge clk);
		rst_n = 1'b1;
	end

	// ************************************************************
	// Helpers
	// ************************************************************

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks_done++;
		if (actual !== expected) begin
			abort_run($sformatf("Fail at %0t: %s is %h, expected %h",
				$time, name, actual, expected));
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per bit
	task automatic random_word(output logic [31:0] word);
		word = '0;
		for (int b = 0; b < 32; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			word = {word[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [MMIO_DW-1:0] word_of(input logic [PAD_W-1:0] v, input int idx);
		return v[idx*MMIO_DW +: MMIO_DW];
	endfunction

	// Appends one step, computes its read data and advances the model by one edge
	task automatic push_step(input logic [1:0] op, input logic [MMIO_AW-1:0] addr,
		input logic [MMIO_DW-1:0] wdata);
		step_t            s;
		logic [PAD_W-1:0] loaded;
		logic             count_rd;
		logic             load_wr;
		logic             ctrl_wr;
		logic             load_now;
		s.op       = op;
		s.addr     = addr;
		s.wdata    = wdata;
		s.check    = (op == OP_READ);
		s.expected = '0;
		if (op == OP_READ) begin
			if (addr == REG_CTRL) begin
				s.expected = {{(MMIO_DW-1){1'b0}}, m_run};
			end else if (addr == REG_COUNT) begin
				// Word 0 is live, later words come from the frozen copy
				if (m_rd_idx == 0)
					s.expected = word_of(PAD_W'(m_count), 0);
				else
					s.expected = word_of(PAD_W'(m_snapshot), m_rd_idx);
			end
		end
		count_rd = (op == OP_READ) && (addr == REG_COUNT);
		load_wr  = (op == OP_WRITE) && (addr == REG_LOAD);
		ctrl_wr  = (op == OP_WRITE) && (addr == REG_CTRL);
		loaded   = m_gather;
		if (load_wr)
			loaded[m_wr_idx*MMIO_DW +: MMIO_DW] = wdata;
		load_now = load_wr && (m_wr_idx == NUM_WORDS - 1);
		// Edge at the end of the step
		if (count_rd && m_rd_idx == 0)
			m_snapshot = m_count;
		if (load_now)
			m_count = loaded[BW_WIDE-1:0];
		else if (m_run)
			m_count = m_count + BW_WIDE'(1);
		if (load_wr)
			m_gather = loaded;
		// Clear pulse from the previous step wins over advancing
		if (m_clr_pending) begin
			m_rd_idx = 0;
			m_wr_idx = 0;
		end else begin
			if (count_rd)
				m_rd_idx = (m_rd_idx + 1) % NUM_WORDS;
			if (load_wr)
				m_wr_idx = (m_wr_idx + 1) % NUM_WORDS;
		end
		if (ctrl_wr) begin
			m_run         = wdata[CTRL_RUN];
			m_clr_pending = wdata[CTRL_CLEAR];
		end else begin
			m_clr_pending = 1'b0;
		end
		if (num_steps >= MAX_STEPS)
			abort_run("Stimulus table overflow, too many steps");
		else begin
			steps[num_steps] = s;
			num_steps++;
		end
	endtask

	task automatic read_reg(input logic [MMIO_AW-1:0] addr);
		push_step(OP_READ, addr, '0);
	endtask

	task automatic write_reg(input logic [MMIO_AW-1:0] addr, input logic [MMIO_DW-1:0] data);
		push_step(OP_WRITE, addr, data);
	endtask

	task automatic idle_cycles(input int n);
		for (int c = 0; c < n; c++) begin
			push_step(OP_IDLE, '0, '0);
		end
	endtask

	// ************************************************************
	// Stimulus table
	// ************************************************************

	task automatic build_table();
		logic [31:0] w0;
		logic [31:0] w1;
		// Reset values
		read_reg(REG_CTRL);
		read_reg(REG_COUNT);
		read_reg(REG_COUNT);
		// Load while stopped, value holds
		random_word(w0);
		random_word(w1);
		write_reg(REG_LOAD, w0);
		write_reg(REG_LOAD, w1);
		idle_cycles(2);
		read_reg(REG_COUNT);
		read_reg(REG_COUNT);
		// Count for a few cycles then stop
		random_word(w0);
		random_word(w1);
		write_reg(REG_LOAD, w0);
		write_reg(REG_LOAD, w1);
		write_reg(REG_CTRL, 32'h1);
		idle_cycles(RUN_CYCLES);
		write_reg(REG_CTRL, 32'h0);
		read_reg(REG_COUNT);
		read_reg(REG_COUNT);
		// Partial load dropped by CLEAR
		random_word(w0);
		write_reg(REG_LOAD, w0);
		write_reg(REG_CTRL, 32'h2);
		idle_cycles(1);
		random_word(w0);
		random_word(w1);
		write_reg(REG_LOAD, w0);
		write_reg(REG_LOAD, w1);
		read_reg(REG_COUNT);
		read_reg(REG_COUNT);
		// Partial read restarted by CLEAR
		read_reg(REG_COUNT);
		write_reg(REG_CTRL, 32'h2);
		idle_cycles(1);
		read_reg(REG_COUNT);
		read_reg(REG_COUNT);
		// Carry into the high word after the snapshot
		random_word(w1);
		write_reg(REG_CTRL, 32'h1);
		write_reg(REG_LOAD, 32'hFFFF_FFFE);
		write_reg(REG_LOAD, w1);
		read_reg(REG_COUNT);
		idle_cycles(3);
		read_reg(REG_COUNT);
		write_reg(REG_CTRL, 32'h0);
		// Unmapped offset and control readback
		read_reg(4'hC);
		write_reg(REG_CTRL, 32'h1);
		read_reg(REG_CTRL);
		write_reg(REG_CTRL, 32'h0);
		read_reg(REG_CTRL);
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1) begin
			if (cycles >= RESET_TIMEOUT) begin
				abort_run("Timeout, reset was never released");
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
	endtask

	// ************************************************************
	// Main sequence
	// ************************************************************

	initial begin
		req           = '0;
		num_steps     = 0;
		checks_done   = 0;
		lfsr_state    = 32'h504;
		m_count       = '0;
		m_snapshot    = '0;
		m_gather      = '0;
		m_run         = 1'b0;
		m_clr_pending = 1'b0;
		m_rd_idx      = 0;
		m_wr_idx      = 0;
		build_table();
		wait_reset_release();
		for (int i = 0; i < num_steps; i++) begin
			@(negedge clk);
			req.addr  = steps[i].addr;
			req.re    = (steps[i].op == OP_READ);
			req.we    = (steps[i].op == OP_WRITE);
			req.wdata = steps[i].wdata;
			// rdata settles well before the next rising edge
			#(CLK_PERIOD/4);
			if (steps[i].check)
				check_value($sformatf("rdata[step %0d]", i), rdata, steps[i].expected);
		end
		@(negedge clk);
		req = '0;
		$display("%0d read checks over %0d steps", checks_done, num_steps);
		$display("Simulation PASSED");
		$finish;
	end

endmodule : tb_mmio_wide_timer

`default_nettype wire

//--- source/mmio_wide_timer_top.sv
// Memory-mapped wide cycle timer behind a 32-bit MMIO bus
`timescale 1ns/10ps
`default_nettype none

module mmio_wide_timer_top #(
	parameter int BW_WIDE = 64
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  mmio_wide_pkg::mmio_req_t          req,
	output logic [mmio_wide_pkg::MMIO_DW-1:0] rdata
);

	import mmio_wide_pkg::*;

	// Decoder strobes and control
	logic               count_re;
	logic               load_we;
	logic [MMIO_DW-1:0] wdata;
	logic               run;
	logic               seq_clear;

	// Read path
	logic [MMIO_DW-1:0] word_rdata;
	logic               snapshot_take;
	logic [BW_WIDE-1:0] count_view;

	// Write path
	logic [BW_WIDE-1:0] wide_load_value;
	logic               load_strobe;

	mmio_reg_decoder u_decoder (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.word_rdata(word_rdata),
		.rdata     (rdata),
		.count_re  (count_re),
		.load_we   (load_we),
		.wdata     (wdata),
		.run       (run),
		.seq_clear (seq_clear)
	);

	mmio_wide_read #(.BW_WIDE(BW_WIDE)) u_wide_read (
		.clk          (clk),
		.rst_n        (rst_n),
		.clear        (seq_clear),
		.re           (count_re),
		.wide_data_in (count_view),
		.rdata        (word_rdata),
		.snapshot_take(snapshot_take)
	);

	mmio_wide_write #(.BW_WIDE(BW_WIDE)) u_wide_write (
		.clk          (clk),
		.rst_n        (rst_n),
		.clear        (seq_clear),
		.we           (load_we),
		.wdata        (wdata),
		.wide_data_out(wide_load_value),
		.load_strobe  (load_strobe)
	);

	wide_timer #(.BW_WIDE(BW_WIDE)) u_timer (
		.clk          (clk),
		.rst_n        (rst_n),
		.run          (run),
		.load_strobe  (load_strobe),
		.load_value   (wide_load_value),
		.snapshot_take(snapshot_take),
		.count_view   (count_view)
	);

endmodule : mmio_wide_timer_top

`default_nettype wire

//--- source/mmio_reg_decoder.sv
// MMIO register decoder holding the control register and selecting the read data
`timescale 1ns/10ps
`default_nettype none

module mmio_reg_decoder (
	input  logic                              clk,
	input  logic                              rst_n,
	input  mmio_wide_pkg::mmio_req_t          req,
	input  logic [mmio_wide_pkg::MMIO_DW-1:0] word_rdata,
	output logic [mmio_wide_pkg::MMIO_DW-1:0] rdata,
	output logic                              count_re,
	output logic                              load_we,
	output logic [mmio_wide_pkg::MMIO_DW-1:0] wdata,
	output logic                              run,
	output logic                              seq_clear
);

	import mmio_wide_pkg::*;

	// Address hits
	logic               hit_ctrl;
	logic               hit_count;
	logic               hit_load;
	// Control register as seen on the bus
	logic [MMIO_DW-1:0] ctrl_rdata;

	// ************************************************************
	// Address decode
	// ************************************************************

	assign hit_ctrl  = (req.addr == REG_CTRL);
	assign hit_count = (req.addr == REG_COUNT);
	assign hit_load  = (req.addr == REG_LOAD);

	// Strobes to the serial ports
	assign count_re = req.re & hit_count;
	assign load_we  = req.we & hit_load;
	assign wdata    = req.wdata;

	// ************************************************************
	// Control register
	// ************************************************************

	// RUN is stored, CLEAR becomes a one-cycle pulse
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run       <= 1'b0;
			seq_clear <= 1'b0;
		end else if (req.we && hit_ctrl) begin
			run       <= req.wdata[CTRL_RUN];
			seq_clear <= req.wdata[CTRL_CLEAR];
		end else begin
			seq_clear <= 1'b0;
		end
	end

	// CLEAR always reads back as 0
	always_comb begin
		ctrl_rdata           = '0;
		ctrl_rdata[CTRL_RUN] = run;
	end

	// ************************************************************
	// Read data select
	// ************************************************************

	// Combinational in the read cycle, 0 for unmapped offsets
	always_comb begin
		rdata = '0;
		if (req.re) begin
			if (hit_ctrl) begin
				rdata = ctrl_rdata;
			end else if (hit_count) begin
				rdata = word_rdata;
			end
		end
	end

	// One bus operation per cycle
	a_no_rw_overlap : assert property (
		@(posedge clk) disable iff (!rst_n)
		!(req.re && req.we)
	) else $error("mmio request with both re and we set");

endmodule : mmio_reg_decoder

`default_nettype wire

//--- source/wide_timer.sv
// Wide run/stop cycle counter with parallel load and a coherent read snapshot
`timescale 1ns/10ps
`default_nettype none

module wide_timer #(
	parameter int BW_WIDE = 64
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               run,
	input  logic               load_strobe,
	input  logic [BW_WIDE-1:0] load_value,
	input  logic               snapshot_take,
	output logic [BW_WIDE-1:0] count_view
);

	// Live count
	logic [BW_WIDE-1:0] count;
	// Value frozen at the first word of a read sequence
	logic [BW_WIDE-1:0] snapshot;

	// ************************************************************
	// Counter
	// ************************************************************

	// Load has priority over increment
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (load_strobe) begin
			count <= load_value;
		end else if (run) begin
			count <= count + BW_WIDE'(1);
		end
	end

	// ************************************************************
	// Read snapshot
	// ************************************************************

	// Whole count taken in one edge so later words cannot tear
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			snapshot <= '0;
		end else if (snapshot_take) begin
			snapshot <= count;
		end
	end

	// Word 0 comes straight from the live count
	// the rest from the frozen copy
	always_comb begin
		if (snapshot_take) begin
			count_view = count;
		end else begin
			count_view = snapshot;
		end
	end

	// A stopped timer without a load holds its value
	a_count_hold : assert property (
		@(posedge clk) disable iff (!rst_n)
		(!run && !load_strobe) |=> $stable(count)
	) else $error("wide_timer count moved while stopped");

endmodule : wide_timer

`default_nettype wire

//--- source/mmio_wide_write.sv
// Gathers successive 32-bit MMIO writes into a wide word and strobes it when complete
`timescale 1ns/10ps
`default_nettype none

module mmio_wide_write #(
	parameter int BW_WIDE = 64
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              clear,
	input  logic                              we,
	input  logic [mmio_wide_pkg::MMIO_DW-1:0] wdata,
	output logic [BW_WIDE-1:0]                wide_data_out,
	output logic                              load_strobe
);

	import mmio_wide_pkg::*;

	localparam int NUM_WORDS = (BW_WIDE + MMIO_DW - 1) / MMIO_DW;
	localparam int PAD_WIDTH = NUM_WORDS * MMIO_DW;

	// Word position of the next write
	logic [NUM_WORDS-1:0] word_sel;
	logic                 at_last;

	// Gathered words, payload only
	logic [PAD_WIDTH-1:0] gather;
	// Gathered words with the word being written merged in
	logic [PAD_WIDTH-1:0] merged;

	// ************************************************************
	// Word sequencer
	// ************************************************************

	onehot_counter #(
		.COUNT_LENGTH(NUM_WORDS)
	) u_write_cnt (
		.clk     (clk),
		.rst_n   (rst_n),
		.init    (clear),
		.count   (we),
		.value   (word_sel),
		.is_first(),
		.is_last (at_last)
	);

	// Capture each written word into its own slot
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_WORDS; i++) begin
			if (we && word_sel[i]) begin
				gather[i*MMIO_DW +: MMIO_DW] <= wdata;
			end
		end
	end

	// Bypass the current write so the load sees the last word this cycle
	always_comb begin
		for (int i = 0; i < NUM_WORDS; i++) begin
			merged[i*MMIO_DW +: MMIO_DW] = (we && word_sel[i]) ? wdata :
				gather[i*MMIO_DW +: MMIO_DW];
		end
	end

	// Drop the pad bits of a partial top word
	assign wide_data_out = merged[BW_WIDE-1:0];

	// Sequence is complete on the write of the last word
	assign load_strobe = we & at_last;

endmodule : mmio_wide_write

`default_nettype wire

//--- source/mmio_wide_read.sv
// Serializes a wide value into successive 32-bit MMIO reads, low word first
`timescale 1ns/10ps
`default_nettype none

module mmio_wide_read #(
	parameter int BW_WIDE = 64
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              clear,
	input  logic                              re,
	input  logic [BW_WIDE-1:0]                wide_data_in,
	output logic [mmio_wide_pkg::MMIO_DW-1:0] rdata,
	output logic                              snapshot_take
);

	import mmio_wide_pkg::*;

	// Bus words needed to cover the wide value
	localparam int NUM_WORDS = (BW_WIDE + MMIO_DW - 1) / MMIO_DW;

	// Current word position, one-hot
	logic [NUM_WORDS-1:0] word_sel;
	// Sequencer sits on word 0
	logic                 at_first;

	// ************************************************************
	// Word sequencer
	// ************************************************************

	// Each read advances one word, wraps after the last one
	onehot_counter #(
		.COUNT_LENGTH(NUM_WORDS)
	) u_read_cnt (
		.clk     (clk),
		.rst_n   (rst_n),
		.init    (clear),
		.count   (re),
		.value   (word_sel),
		.is_first(at_first),
		.is_last ()
	);

	// Word select into the bus data
	onehot_mux #(
		.NUM_WORDS(NUM_WORDS),
		.BW_WIDE  (BW_WIDE)
	) u_read_mux (
		.data_in (wide_data_in),
		.select  (word_sel),
		.data_out(rdata)
	);

	// First word of a sequence freezes the whole value in the timer
	assign snapshot_take = re & at_first;

endmodule : mmio_wide_read

`default_nettype wire

//--- source/onehot_mux.sv
// One-hot select multiplexer picking one bus word out of a wide value
`timescale 1ns/10ps
`default_nettype none

module onehot_mux #(
	parameter int NUM_WORDS = 2,
	parameter int BW_WIDE   = 64
) (
	input  logic [BW_WIDE-1:0]                data_in,
	input  logic [NUM_WORDS-1:0]              select,
	output logic [mmio_wide_pkg::MMIO_DW-1:0] data_out
);

	import mmio_wide_pkg::*;

	// Wide value rounded up to whole bus words
	localparam int PAD_WIDTH = NUM_WORDS * MMIO_DW;

	logic [PAD_WIDTH-1:0] padded;

	// Zero-pad the top word when the width is not a word multiple
	always_comb begin
		padded = '0;
		padded[BW_WIDE-1:0] = data_in;
	end

	// AND-OR tree, each word gated by its select bit
	// With a one-hot select only one word survives
	always_comb begin
		data_out = '0;
		for (int i = 0; i < NUM_WORDS; i++) begin
			data_out = data_out | (padded[i*MMIO_DW +: MMIO_DW] & {MMIO_DW{select[i]}});
		end
	end

endmodule : onehot_mux

`default_nettype wire

//--- source/onehot_counter.sv
// Circular one-hot word counter with init and first/last word flags
`timescale 1ns/10ps
`default_nettype none

module onehot_counter #(
	parameter int COUNT_LENGTH = 2
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    init,
	input  logic                    count,
	output logic [COUNT_LENGTH-1:0] value,
	output logic                    is_first,
	output logic                    is_last
);

	// Next position of the ring, one step up with wrap to bit 0
	logic [COUNT_LENGTH-1:0] value_next;

	// Rotate left by one
	// Modulo index keeps a single-word ring legal too
	always_comb begin
		for (int i = 0; i < COUNT_LENGTH; i++) begin
			value_next[i] = value[(i + COUNT_LENGTH - 1) % COUNT_LENGTH];
		end
	end

	// ************************************************************
	// Ring register
	// ************************************************************

	// Init beats count, both land on word 0
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			value <= COUNT_LENGTH'(1);
		end else if (init) begin
			value <= COUNT_LENGTH'(1);
		end else if (count) begin
			value <= value_next;
		end
	end

	// Position flags for the word sequencers
	assign is_first = value[0];
	assign is_last  = value[COUNT_LENGTH-1];

	// The ring must never lose or duplicate its token across rotations
	a_value_onehot : assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot(value)
	) else $error("onehot_counter value is not one-hot: %b", value);

endmodule : onehot_counter

`default_nettype wire

//--- source/mmio_wide_pkg.sv
// MMIO wide timer package with the bus request type, register map and control bits
`default_nettype none

package mmio_wide_pkg;

	// ************************************************************
	// Bus geometry
	// ************************************************************

	// Data word of the MMIO bus, fixed by the interconnect
	localparam int MMIO_DW = 32;
	// Register offset width, enough for four word registers
	localparam int MMIO_AW = 4;

	// One bus request per cycle
	// Plain strobes, no handshake and no byte enables
	typedef struct packed {
		logic [MMIO_AW-1:0] addr;
		logic               re;
		logic               we;
		logic [MMIO_DW-1:0] wdata;
	} mmio_req_t;

	// ************************************************************
	// Register map
	// ************************************************************

	// Control register, read/write
	localparam logic [MMIO_AW-1:0] REG_CTRL  = 4'h0;
	// Timer value, read port, low word first
	localparam logic [MMIO_AW-1:0] REG_COUNT = 4'h4;
	// Timer load value, write port, low word first
	localparam logic [MMIO_AW-1:0] REG_LOAD  = 4'h8;

	// ************************************************************
	// Control register bits
	// ************************************************************

	// Stored run enable
	localparam int CTRL_RUN   = 0;
	// Self-clearing, restarts both word sequencers
	localparam int CTRL_CLEAR = 1;

endpackage : mmio_wide_pkg

`default_nettype wire
